/* Makefile */
# Verilator build for the 2x2 max-pooling unit

VERILATOR ?= verilator
TOP       ?= pool_unit_tb
RTL_TOP   ?= pool_unit_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only if the log holds the pass line
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/pool_buffer.sv */
`timescale 1ns/10ps

module pool_buffer
    import pool_types_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      wr_hold,
    input  pix_t      hold_data,
    input  logic      wr_row,
    input  buf_adrs_t row_adrs,
    input  pix_t      row_data,
    output pix_t      hold_q,
    output pix_t      row_q
);

    pix_t mem [buf_depth];                            // entries 0..13 half-row, 15 hold

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < buf_depth; i++)
                mem[i] <= '0;
        end
        else
        begin
            if (wr_row)
                mem[row_adrs] <= row_data;
            if (wr_hold)
                mem[hold_adrs] <= hold_data;          // port 1 is tied to the hold entry
        end
    end

    // combinational reads so the working row sees the pair stored a row earlier
    assign hold_q = mem[hold_adrs];
    assign row_q  = mem[row_adrs];

endmodule

/* logic/pool_bus_pkg.sv */
package pool_bus_pkg;

    typedef logic [7:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
        logic    sel;                                 // single byte lane group, not decoded
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // register map, word aligned
    localparam wb_adr_t reg_ctrl   = 8'h00;           // bit 0 written as 1 starts a frame
    localparam wb_adr_t reg_status = 8'h04;           // bit 0 busy, bit 1 done
    localparam wb_adr_t reg_count  = 8'h08;           // pooled results of the last frame

endpackage

/* logic/pool_datapath.sv */
`timescale 1ns/10ps

module pool_datapath
    import pool_types_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  pix_t      pix,
    input  pool_cmd_t cmd,
    input  pix_t      hold_q,
    input  pix_t      row_q,
    output pix_t      hold_data,
    output pix_t      row_data,
    output logic      wr_hold,
    output logic      wr_row,
    output buf_adrs_t row_adrs,
    output logic      pool_valid,
    output pix_t      pool_data
);

    pix_t pair_max;
    pix_t window_max;

    function automatic pix_t pix_max(input pix_t a, input pix_t b);
        pix_t m;
        m = (a > b) ? a : b;                          // pixels are unsigned
        return m;
    endfunction

    assign pair_max   = pix_max(hold_q, pix);         // horizontal pair of the current row
    assign window_max = pix_max(pair_max, row_q);     // add the pair stored from the row above

    // buffer writes follow the controller command
    assign hold_data = pix;
    assign row_data  = pair_max;
    assign wr_hold   = cmd.wr_hold;
    assign wr_row    = cmd.wr_row;
    assign row_adrs  = cmd.row_adrs;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            pool_valid <= 1'b0;
        else
            pool_valid <= cmd.emit;
    end

    always_ff @(posedge clk)
    begin
        if (cmd.emit)
            pool_data <= window_max;
    end

endmodule

/* logic/pool_regs.sv */
`timescale 1ns/10ps

module pool_regs
    import pool_bus_pkg::*;
#(
    parameter int img_width = 28
)(
    input  logic    clk,
    input  logic    nrst,
    input  wb_req_t wb_req,
    input  logic    busy,
    input  logic    pool_done,
    input  logic    pool_valid,
    output wb_rsp_t wb_rsp,
    output logic    start
);

    // one result per 2x2 window
    localparam int count_w = $clog2((img_width / 2) * (img_width / 2) + 1);
    typedef logic [count_w-1:0] count_t;

    logic    ack_q;
    wb_dat_t rd_dat_q;
    logic    access;
    logic    start_hit;
    logic    pending;                                 // start issued, stream not yet running
    logic    busy_all;
    logic    done;
    count_t  count;

    assign access    = wb_req.cyc && wb_req.stb && !ack_q;
    assign busy_all  = busy || pending;
    assign start_hit = access && wb_req.we && (wb_req.adr == reg_ctrl)
                       && wb_req.dat[0] && !busy_all;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            ack_q    <= 1'b0;
            rd_dat_q <= '0;
            start    <= 1'b0;
            pending  <= 1'b0;
            done     <= 1'b0;
            count    <= '0;
        end
        else
        begin
            ack_q <= access;                          // one cycle after cyc and stb
            start <= start_hit;
            if (start_hit)
                pending <= 1'b1;
            else if (busy)
                pending <= 1'b0;                      // controller has taken the frame
            if (start_hit)
                done <= 1'b0;
            else if (pool_done)
                done <= 1'b1;
            if (start_hit)
                count <= '0;
            else if (pool_valid)
                count <= count + 1'b1;
            if (access && !wb_req.we)
            begin
                unique case (wb_req.adr)
                    reg_status: rd_dat_q <= {30'b0, done, busy_all};
                    reg_count:  rd_dat_q <= wb_dat_t'(count);
                    default:    rd_dat_q <= '0;       // control reads back as zero
                endcase
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;

endmodule

/* logic/pool_types_pkg.sv */
package pool_types_pkg;

    localparam int pix_w = 16;                        // width of one feature-map pixel
    typedef logic [pix_w-1:0] pix_t;

    localparam int buf_adrs_w = 4;
    typedef logic [buf_adrs_w-1:0] buf_adrs_t;

    localparam int buf_depth = 1 << buf_adrs_w;       // 16 entries, half-row plus hold
    localparam buf_adrs_t hold_adrs = 4'hf;           // top entry keeps the even-column pixel

    // row and column counters reach 27 at most
    typedef logic [4:0] pos_t;

    typedef struct packed {
        logic      wr_hold;                           // store the current pixel at hold_adrs
        logic      wr_row;                            // store the pair maximum at row_adrs
        buf_adrs_t row_adrs;                          // half-row entry of the current pair
        logic      emit;                              // form the window maximum this cycle
        logic      first_row_pair;                    // spare bit, always zero
        logic [2:0] reserved;                         // pads the command to 11 bits
    } pool_cmd_t;

endpackage

/* logic/pool_unit_top.sv */
`timescale 1ns/10ps

module pool_unit_top
    import pool_types_pkg::*;
    import pool_bus_pkg::*;
#(
    parameter int img_width = 28
)(
    input  logic    clk,
    input  logic    nrst,
    input  wb_req_t wb_req,
    input  pix_t    pix,
    output wb_rsp_t wb_rsp,
    output logic    pix_ready,
    output logic    pool_valid,
    output pix_t    pool_data
);

    logic      start;
    logic      pool_done;
    pool_cmd_t cmd;
    pix_t      hold_q;
    pix_t      row_q;
    pix_t      hold_data;
    pix_t      row_data;
    logic      wr_hold;
    logic      wr_row;
    buf_adrs_t row_adrs;

    pool_regs #(.img_width(img_width)) u_regs (
        .clk        (clk),
        .nrst       (nrst),
        .wb_req     (wb_req),
        .busy       (pix_ready),                      // stream activity marks the unit busy
        .pool_done  (pool_done),
        .pool_valid (pool_valid),
        .wb_rsp     (wb_rsp),
        .start      (start)
    );

    pooling_control #(.img_width(img_width)) u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .pix_ready  (pix_ready),
        .cmd        (cmd),
        .pool_done  (pool_done)
    );

    pool_buffer u_buf (
        .clk        (clk),
        .nrst       (nrst),
        .wr_hold    (wr_hold),
        .hold_data  (hold_data),
        .wr_row     (wr_row),
        .row_adrs   (row_adrs),
        .row_data   (row_data),
        .hold_q     (hold_q),
        .row_q      (row_q)
    );

    pool_datapath u_dp (
        .clk        (clk),
        .nrst       (nrst),
        .pix        (pix),
        .cmd        (cmd),
        .hold_q     (hold_q),
        .row_q      (row_q),
        .hold_data  (hold_data),
        .row_data   (row_data),
        .wr_hold    (wr_hold),
        .wr_row     (wr_row),
        .row_adrs   (row_adrs),
        .pool_valid (pool_valid),
        .pool_data  (pool_data)
    );

endmodule

/* logic/pooling_control.sv */
`timescale 1ns/10ps

module pooling_control
    import pool_types_pkg::*;
#(
    parameter int img_width = 28
)(
    input  logic      clk,
    input  logic      nrst,
    input  logic      start,
    output logic      pix_ready,
    output pool_cmd_t cmd,
    output logic      pool_done
);

    typedef enum logic [1:0] {
        idle      = 2'b00,
        buffering = 2'b01,                            // even row, pair maxima go to the buffer
        working   = 2'b10                             // odd row, pairs meet their stored half
    } pool_state_t;

    localparam pos_t last_pos = pos_t'(img_width - 1);

    pool_state_t state, next_state;
    pos_t        col, next_col;
    pos_t        row, next_row;
    logic        last_col;
    logic        frame_end;

    assign pix_ready = (state != idle);
    assign last_col  = (col == last_pos);
    assign frame_end = (state == working) && last_col && (row == last_pos);

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            state     <= idle;
            col       <= '0;
            row       <= '0;
            pool_done <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            col       <= next_col;
            row       <= next_row;
            pool_done <= frame_end;                   // high in the first idle cycle
        end
    end

    always_comb
    begin
        next_state = state;
        next_col   = col;
        next_row   = row;
        unique case (state)
            idle:
            begin
                next_col = '0;
                next_row = '0;
                if (start)
                    next_state = buffering;
            end
            buffering:
            begin
                next_col = col + 1'b1;
                if (last_col)
                begin
                    next_col   = '0;
                    next_row   = row + 1'b1;
                    next_state = working;
                end
            end
            working:
            begin
                next_col = col + 1'b1;
                if (last_col)
                begin
                    next_col = '0;
                    next_row = row + 1'b1;
                    if (row == last_pos)
                        next_state = idle;            // last working row is done
                    else
                        next_state = buffering;
                end
            end
            default:
            begin
                next_state = idle;
            end
        endcase
    end

    // command for the pixel on the stream in this same cycle
    always_comb
    begin
        cmd = '0;
        if (state != idle)
        begin
            cmd.row_adrs = col[4:1];                  // pair index is column / 2
            if (!col[0])
                cmd.wr_hold = 1'b1;
            else if (state == buffering)
                cmd.wr_row = 1'b1;
            else
                cmd.emit = 1'b1;
        end
    end

endmodule

/* sources.f */
logic/pool_types_pkg.sv
logic/pool_bus_pkg.sv
logic/pooling_control.sv
logic/pool_buffer.sv
logic/pool_datapath.sv
logic/pool_regs.sv
logic/pool_unit_top.sv
tb/pool_unit_tb.sv

/* tb/pool_unit_tb.sv */
`timescale 1ns/10ps

module pool_unit_tb
    import pool_types_pkg::*;
    import pool_bus_pkg::*;
();

    localparam int img_width   = 28;
    localparam int frame_pix   = img_width * img_width;
    localparam int frame_res   = frame_pix / 4;         // one result per 2x2 window
    localparam int n_frames    = 3;
    localparam int cycle_limit = n_frames * frame_pix + 2000;

    typedef logic [9:0] idx_t;

    logic        clk;
    logic        nrst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    pix_t        pix;
    logic        pix_ready;
    logic        pool_valid;
    pix_t        pool_data;

    pix_t        frame_mem [1024];
    pix_t        exp_mem [1024];                        // expected results of all frames in order
    pix_t        exp_q [$];
    idx_t        exp_cnt;
    idx_t        res_idx = '0;
    pix_t        exp_head;
    logic        model_emit;                            // current pixel closes a 2x2 window
    int          ready_run = 0;
    int          assert_fails = 0;
    int          check_fails;
    int          tests_ok;
    int          tests_bad;
    int          fails_before;
    int          cycle_cnt;
    logic [31:0] lcg_state;

    pool_unit_top #(.img_width(img_width)) u_dut (
        .clk        (clk),
        .nrst       (nrst),
        .wb_req     (wb_req),
        .pix        (pix),
        .wb_rsp     (wb_rsp),
        .pix_ready  (pix_ready),
        .pool_valid (pool_valid),
        .pool_data  (pool_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_limit);
        $display("test failed");
        $finish;
    end

    // pixel source, one pixel per pix_ready cycle in row order
    initial
    begin : stream_driver
        int drv_row;
        int drv_col;
        pix        = '0;
        model_emit = 1'b0;
        drv_row    = 0;
        drv_col    = 0;
        forever
        begin
            @(negedge clk);
            if (pix_ready)
            begin
                pix        = frame_mem[idx_t'(drv_row * img_width + drv_col)];
                model_emit = (drv_row % 2 == 1) && (drv_col % 2 == 1);
                drv_col    = (drv_col == img_width - 1) ? 0 : drv_col + 1;
                drv_row    = (drv_col == 0) ? drv_row + 1 : drv_row;
            end
            else
            begin
                pix        = '0;
                model_emit = 1'b0;
                drv_row    = 0;
                drv_col    = 0;
            end
        end
    end

    always @(posedge clk)
    begin
        if (pool_valid)
            res_idx <= res_idx + 1'b1;
        ready_run <= pix_ready ? ready_run + 1 : 0;   // length of the current stream burst
    end

    assign exp_head = exp_mem[res_idx];

    a_data: assert property (@(posedge clk) disable iff (!nrst)
        pool_valid |-> (res_idx < exp_cnt) && (pool_data == exp_head))
    else
    begin
        $display("Mismatch pool_data: got %h expected %h at result %0d",
                 $sampled(pool_data), $sampled(exp_head), $sampled(res_idx));
        assert_fails++;
    end

    a_valid: assert property (@(posedge clk) disable iff (!nrst)
        pool_valid == $past(model_emit))
    else
    begin
        $display("Mismatch pool_valid: got %h expected %h",
                 $sampled(pool_valid), $past(model_emit));
        assert_fails++;
    end

    a_ready_max: assert property (@(posedge clk) disable iff (!nrst)
        pix_ready |-> ready_run < frame_pix)
    else
    begin
        $display("pix_ready stayed high longer than one frame");
        assert_fails++;
    end

    a_ready_len: assert property (@(posedge clk) disable iff (!nrst)
        $fell(pix_ready) |-> ready_run == frame_pix)
    else
    begin
        $display("Mismatch pix_ready cycles: got %h expected %h", $sampled(ready_run), frame_pix);
        assert_fails++;
    end

    a_ack: assert property (@(posedge clk) disable iff (!nrst)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack ##1 !wb_rsp.ack)
    else
    begin
        $display("ack did not come as a single pulse one cycle after stb");
        assert_fails++;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pix_t bigger(input pix_t a, input pix_t b);
        return (a > b) ? a : b;
    endfunction

    task automatic wb_access(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                             output wb_dat_t rdat);
        wb_req     = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do
        begin
            @(negedge clk);
        end
        while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;
        wb_req = '0;
        @(negedge clk);                                 // idle cycle between accesses
    endtask

    task automatic expect_reg(input wb_adr_t adr, input wb_dat_t want, input string name);
        wb_dat_t got;
        wb_access(adr, 1'b0, '0, got);
        assert (got == want)
        else
        begin
            $display("Mismatch %s: got %h expected %h", name, got, want);
            check_fails++;
        end
    endtask

    task automatic start_frame();
        wb_dat_t rdat;
        wb_access(reg_ctrl, 1'b1, 32'h1, rdat);
    endtask

    task automatic wait_frame_done();
        wb_dat_t status;
        status = '0;
        while (!status[1])
            wb_access(reg_status, 1'b0, '0, status);
    endtask

    // expected results of one frame in row-major pool order
    task automatic build_expected();
        int   top;
        pix_t upper;
        pix_t lower;
        for (int pr = 0; pr < img_width / 2; pr++)
        begin
            for (int pc = 0; pc < img_width / 2; pc++)
            begin
                top   = 2 * pr * img_width + 2 * pc;  // top-left pixel of the window
                upper = bigger(frame_mem[idx_t'(top)], frame_mem[idx_t'(top + 1)]);
                lower = bigger(frame_mem[idx_t'(top + img_width)],
                               frame_mem[idx_t'(top + img_width + 1)]);
                exp_q.push_back(bigger(upper, lower));
            end
        end
        while (exp_q.size() > 0)
        begin
            exp_mem[exp_cnt] = exp_q.pop_front();
            exp_cnt          = exp_cnt + 1'b1;
        end
    endtask

    task automatic load_frame(input logic falling);
        for (int i = 0; i < frame_pix; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            frame_mem[idx_t'(i)] = falling ? pix_t'(16'hf000 - 3 * i) : lcg_state[31:16];
        end
        build_expected();
    endtask

    task automatic check_results_and_idle();
        assert (res_idx == exp_cnt)
        else
        begin
            $display("only %0d of %0d pooled results arrived", res_idx, exp_cnt);
            check_fails++;
        end
        assert (!pix_ready && !pool_valid)
        else
        begin
            $display("Mismatch pix_ready/pool_valid: got %h/%h expected 0/0", pix_ready, pool_valid);
            check_fails++;
        end
    endtask

    task automatic end_test(input string name);
        if (assert_fails + check_fails == fails_before)
        begin
            tests_ok++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("%s: errors found", name);
        end
        fails_before = assert_fails + check_fails;
    endtask

    initial
    begin : main_sequence
        wb_req       = '0;
        nrst         = 1'b0;
        lcg_state    = 32'h5761a566;
        exp_cnt      = '0;
        check_fails  = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        fails_before = 0;
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        expect_reg(reg_ctrl, 32'h0, "reg_ctrl");
        expect_reg(reg_status, 32'h0, "reg_status");
        expect_reg(reg_count, 32'h0, "reg_count");
        check_results_and_idle();
        end_test("reset values and bus timing");

        load_frame(1'b0);
        start_frame();
        wait_frame_done();
        end_test("random frame pooling");

        check_results_and_idle();
        expect_reg(reg_count, wb_dat_t'(frame_res), "reg_count");
        expect_reg(reg_status, 32'h2, "reg_status");
        end_test("status after frame");

        load_frame(1'b1);
        start_frame();
        expect_reg(reg_status, 32'h1, "reg_status");   // busy, done cleared by start
        wait_frame_done();
        check_results_and_idle();
        expect_reg(reg_status, 32'h2, "reg_status");
        end_test("falling frame and done bit");

        load_frame(1'b0);
        start_frame();
        repeat (100) @(negedge clk);
        start_frame();
        wait_frame_done();
        repeat (40) @(negedge clk);
        check_results_and_idle();
        expect_reg(reg_count, wb_dat_t'(frame_res), "reg_count");
        end_test("start ignored while busy");

        $display("tests: %0d ok, %0d with errors", tests_ok, tests_bad);
        if (tests_bad == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
